// ==== src/sa_pkg.sv ====
package sa_pkg;

  localparam int SA_N_ENTRIES      = 16;
  localparam int SA_IDX_BITS       = 4;
  localparam int SA_CNT_BITS       = 50;
  localparam int SA_N_EVENTS       = 8;
  localparam int RBUS_ADDR_BITS    = 16;
  localparam int RBUS_DATA_BITS    = 32;
  localparam int SA_LOCL_ADDR_BITS = 8;

  localparam logic [7:0] SA_REVID = 8'h01; // block revision.

  // local byte offsets within the 256-byte window.
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_REVISION_ADDR             = 8'h00;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_SPARE_ADDR                = 8'h04;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_GLOBAL_CTRL_ADDR          = 8'h08;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_CTRL_IA_CONFIG_ADDR       = 8'h10;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_CTRL_IA_STATUS_ADDR       = 8'h14;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_CTRL_IA_WDATA_ADDR        = 8'h18;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_CTRL_IA_RDATA_ADDR        = 8'h1C;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_SNAPSHOT_IA_CONFIG_ADDR   = 8'h20;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_SNAPSHOT_IA_STATUS_ADDR   = 8'h24;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_SNAPSHOT_IA_RDATA_LO_ADDR = 8'h28;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_SNAPSHOT_IA_RDATA_HI_ADDR = 8'h2C;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_COUNT_IA_CONFIG_ADDR      = 8'h30;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_COUNT_IA_STATUS_ADDR      = 8'h34;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_COUNT_IA_RDATA_LO_ADDR    = 8'h38;
  localparam logic [SA_LOCL_ADDR_BITS-1:0] SA_COUNT_IA_RDATA_HI_ADDR    = 8'h3C;

  // per-counter configuration entry.
  typedef struct packed {
    logic       enable;
    logic [2:0] event_sel; // index into the event inputs.
  } sa_ctrl_t;

  typedef struct packed {
    logic [SA_CNT_BITS-1:0] count;
  } sa_stat_t;

  typedef enum logic [3:0] {
    IA_OP_NOP   = 4'd0,
    IA_OP_READ  = 4'd1,
    IA_OP_WRITE = 4'd2
  } sa_ia_op_e;

  typedef enum logic [2:0] {
    IA_OK     = 3'd0,
    IA_BAD_OP = 3'd1
  } sa_ia_code_e;

  // op is kept raw so that unknown codes can be flagged.
  typedef struct packed {
    logic [3:0]             op;
    logic [23:0]            rsvd;
    logic [SA_IDX_BITS-1:0] addr;
  } sa_ia_config_t;

  typedef struct packed {
    sa_ia_code_e            code;
    logic [24:0]            rsvd;
    logic [SA_IDX_BITS-1:0] addr; // entry of the last command.
  } sa_ia_status_t;

endpackage

// ==== src/sa_ring_node.sv ====
`timescale 1ns/1ps

module sa_ring_node (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0]    cfg_start_addr_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0]    cfg_end_addr_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0]    rbus_addr_i,
  input  logic                                 rbus_wr_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0]    rbus_wr_data_i,
  input  logic                                 rbus_rd_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0]    rbus_rd_data_i,
  input  logic                                 rbus_ack_i,
  input  logic                                 rbus_err_ack_i,
  output logic [sa_pkg::RBUS_ADDR_BITS-1:0]    rbus_addr_o,
  output logic                                 rbus_wr_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0]    rbus_wr_data_o,
  output logic                                 rbus_rd_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0]    rbus_rd_data_o,
  output logic                                 rbus_ack_o,
  output logic                                 rbus_err_ack_o,
  output logic [sa_pkg::SA_LOCL_ADDR_BITS-1:0] locl_addr_o,
  output logic                                 locl_wr_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0]    locl_wr_data_o,
  output logic                                 locl_rd_strb_o,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0]    locl_rd_data_i,
  input  logic                                 locl_ack_i,
  input  logic                                 locl_err_ack_i
);
  import sa_pkg::*;

  logic in_range;
  logic locl_rsp;

  assign in_range = (rbus_addr_i >= cfg_start_addr_i) && (rbus_addr_i <= cfg_end_addr_i);
  assign locl_rsp = locl_ack_i | locl_err_ack_i;

  always_ff @(posedge clk) begin
    rbus_addr_o    <= rbus_addr_i;
    rbus_wr_data_o <= rbus_wr_data_i;
    rbus_rd_data_o <= locl_rsp ? locl_rd_data_i : rbus_rd_data_i;
    locl_addr_o    <= rbus_addr_i[SA_LOCL_ADDR_BITS-1:0]; // offset in the window.
    locl_wr_data_o <= rbus_wr_data_i;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rbus_wr_strb_o <= 1'b0;
      rbus_rd_strb_o <= 1'b0;
      rbus_ack_o     <= 1'b0;
      rbus_err_ack_o <= 1'b0;
      locl_wr_strb_o <= 1'b0;
      locl_rd_strb_o <= 1'b0;
    end else begin
      // claimed strobes stop here.
      rbus_wr_strb_o <= rbus_wr_strb_i & ~in_range;
      rbus_rd_strb_o <= rbus_rd_strb_i & ~in_range;
      locl_wr_strb_o <= rbus_wr_strb_i & in_range;
      locl_rd_strb_o <= rbus_rd_strb_i & in_range;
      rbus_ack_o     <= locl_rsp ? locl_ack_i : rbus_ack_i;
      rbus_err_ack_o <= locl_rsp ? locl_err_ack_i : rbus_err_ack_i;
    end
  end

endmodule

// ==== src/sa_regs.sv ====
`timescale 1ns/1ps

module sa_regs (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic [sa_pkg::SA_LOCL_ADDR_BITS-1:0] locl_addr_i,
  input  logic                                 locl_wr_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0]    locl_wr_data_i,
  input  logic                                 locl_rd_strb_i,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0]    locl_rd_data_o,
  output logic                                 locl_ack_o,
  output logic                                 locl_err_ack_o,
  output logic [sa_pkg::SA_LOCL_ADDR_BITS-1:0] reg_addr_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0]    reg_wr_data_o,
  output logic                                 reg_written_o,
  output logic                                 sa_snap_o,
  output logic                                 sa_clear_live_o,
  output sa_pkg::sa_ctrl_t                     ctrl_ia_wdata_o,
  input  sa_pkg::sa_ctrl_t                     ctrl_ia_rdata_i,
  input  sa_pkg::sa_stat_t                     snapshot_ia_rdata_i,
  input  sa_pkg::sa_stat_t                     count_ia_rdata_i,
  input  logic [31:0]                          ctrl_ia_status_i,
  input  logic [31:0]                          snapshot_ia_status_i,
  input  logic [31:0]                          count_ia_status_i
);
  import sa_pkg::*;

  logic [RBUS_DATA_BITS-1:0] spare_q;
  logic [RBUS_DATA_BITS-1:0] rd_mux;
  logic                      rd_hit;
  logic                      glb_wr;

  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (locl_addr_i)
      SA_REVISION_ADDR:             rd_mux = {24'b0, SA_REVID};
      SA_SPARE_ADDR:                rd_mux = spare_q;
      SA_GLOBAL_CTRL_ADDR,
      SA_CTRL_IA_CONFIG_ADDR,
      SA_SNAPSHOT_IA_CONFIG_ADDR,
      SA_COUNT_IA_CONFIG_ADDR:      rd_mux = '0; // write-only commands.
      SA_CTRL_IA_STATUS_ADDR:       rd_mux = ctrl_ia_status_i;
      SA_CTRL_IA_WDATA_ADDR:        rd_mux = 32'(ctrl_ia_wdata_o);
      SA_CTRL_IA_RDATA_ADDR:        rd_mux = 32'(ctrl_ia_rdata_i);
      SA_SNAPSHOT_IA_STATUS_ADDR:   rd_mux = snapshot_ia_status_i;
      SA_SNAPSHOT_IA_RDATA_LO_ADDR: rd_mux = snapshot_ia_rdata_i.count[31:0];
      SA_SNAPSHOT_IA_RDATA_HI_ADDR: rd_mux = 32'(snapshot_ia_rdata_i.count[SA_CNT_BITS-1:32]);
      SA_COUNT_IA_STATUS_ADDR:      rd_mux = count_ia_status_i;
      SA_COUNT_IA_RDATA_LO_ADDR:    rd_mux = count_ia_rdata_i.count[31:0];
      SA_COUNT_IA_RDATA_HI_ADDR:    rd_mux = 32'(count_ia_rdata_i.count[SA_CNT_BITS-1:32]);
      default:                      rd_hit = 1'b0;
    endcase
  end

  // the write seen by the windows one cycle ago.
  assign glb_wr = reg_written_o && (reg_addr_o == SA_GLOBAL_CTRL_ADDR);

  always_ff @(posedge clk) begin
    reg_addr_o     <= locl_addr_i;
    reg_wr_data_o  <= locl_wr_data_i;
    locl_rd_data_o <= (locl_rd_strb_i && rd_hit) ? rd_mux : '0;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      locl_ack_o      <= 1'b0;
      locl_err_ack_o  <= 1'b0;
      reg_written_o   <= 1'b0;
      sa_snap_o       <= 1'b0;
      sa_clear_live_o <= 1'b0;
      spare_q         <= '0;
      ctrl_ia_wdata_o <= '0;
    end else begin
      locl_ack_o      <= (locl_wr_strb_i || locl_rd_strb_i) && rd_hit;
      locl_err_ack_o  <= (locl_wr_strb_i || locl_rd_strb_i) && !rd_hit;
      reg_written_o   <= locl_wr_strb_i;
      sa_snap_o       <= glb_wr && reg_wr_data_o[0]; // self-clearing.
      sa_clear_live_o <= glb_wr && reg_wr_data_o[1];
      if (locl_wr_strb_i && (locl_addr_i == SA_SPARE_ADDR)) begin
        spare_q <= locl_wr_data_i;
      end
      if (locl_wr_strb_i && (locl_addr_i == SA_CTRL_IA_WDATA_ADDR)) begin
        ctrl_ia_wdata_o <= sa_ctrl_t'(locl_wr_data_i[$bits(sa_ctrl_t)-1:0]);
      end
    end
  end

endmodule

// ==== src/sa_indirect_access.sv ====
`timescale 1ns/1ps

module sa_indirect_access #(
  parameter logic [sa_pkg::SA_LOCL_ADDR_BITS-1:0] CMND_ADDR = '0,
  parameter bit                                   WRITABLE  = 1'b0,
  parameter type                                  ENTRY_T   = logic
) (
  input  logic                                 clk,
  input  logic                                 rst_i,
  input  logic [sa_pkg::SA_LOCL_ADDR_BITS-1:0] reg_addr_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0]    reg_wr_data_i,
  input  logic                                 reg_written_i,
  input  ENTRY_T                               wdata_i,
  input  ENTRY_T                               mem_i [sa_pkg::SA_N_ENTRIES],
  output ENTRY_T                               mem_o [sa_pkg::SA_N_ENTRIES],
  output ENTRY_T                               rdata_o,
  output logic [31:0]                          status_o
);
  import sa_pkg::*;

  sa_ia_config_t cmd;
  sa_ia_status_t stat_q;
  logic          cmd_go;
  logic          rd_op;
  logic          wr_op;
  logic          bad_op;

  assign cmd    = sa_ia_config_t'(reg_wr_data_i);
  assign cmd_go = reg_written_i && (reg_addr_i == CMND_ADDR);
  assign rd_op  = (cmd.op == IA_OP_READ);
  assign wr_op  = WRITABLE && (cmd.op == IA_OP_WRITE); // never set on a read-only window.
  assign bad_op = !((cmd.op == IA_OP_NOP) || rd_op || wr_op);

  generate
    if (WRITABLE) begin : g_rw
      always_ff @(posedge clk) begin
        if (rst_i) begin
          for (int i = 0; i < SA_N_ENTRIES; i++) begin
            mem_o[i] <= '0;
          end
        end else if (cmd_go && wr_op) begin
          mem_o[cmd.addr] <= wdata_i;
        end
      end
    end else begin : g_ro
      assign mem_o = mem_i; // external array seen through the window.
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (cmd_go && rd_op) begin
      rdata_o <= mem_o[cmd.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      stat_q <= '0;
    end else if (cmd_go) begin
      stat_q.code <= bad_op ? IA_BAD_OP : IA_OK;
      stat_q.addr <= cmd.addr;
    end
  end

  assign status_o = stat_q;

endmodule

// ==== src/sa_regfile.sv ====
`timescale 1ns/1ps

module sa_regfile (
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0] rbus_addr_i,
  input  logic                              rbus_wr_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_wr_data_i,
  input  logic                              rbus_rd_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_rd_data_i,
  input  logic                              rbus_ack_i,
  input  logic                              rbus_err_ack_i,
  output logic [sa_pkg::RBUS_ADDR_BITS-1:0] rbus_addr_o,
  output logic                              rbus_wr_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_wr_data_o,
  output logic                              rbus_rd_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_rd_data_o,
  output logic                              rbus_ack_o,
  output logic                              rbus_err_ack_o,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0] cfg_start_addr_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0] cfg_end_addr_i,
  output logic                              regs_sa_snap_o,
  output logic                              regs_sa_clear_live_o,
  output sa_pkg::sa_ctrl_t                  regs_sa_ctrl_o [sa_pkg::SA_N_ENTRIES],
  input  sa_pkg::sa_stat_t                  sa_snapshot_i [sa_pkg::SA_N_ENTRIES],
  input  sa_pkg::sa_stat_t                  sa_count_i [sa_pkg::SA_N_ENTRIES]
);
  import sa_pkg::*;

  logic [SA_LOCL_ADDR_BITS-1:0] locl_addr;
  logic                         locl_wr_strb;
  logic [RBUS_DATA_BITS-1:0]    locl_wr_data;
  logic                         locl_rd_strb;
  logic [RBUS_DATA_BITS-1:0]    locl_rd_data;
  logic                         locl_ack;
  logic                         locl_err_ack;
  logic [SA_LOCL_ADDR_BITS-1:0] reg_addr;
  logic [RBUS_DATA_BITS-1:0]    reg_wr_data;
  logic                         reg_written;
  sa_ctrl_t                     ctrl_ia_wdata;
  sa_ctrl_t                     ctrl_ia_rdata;
  sa_stat_t                     snapshot_ia_rdata;
  sa_stat_t                     count_ia_rdata;
  logic [31:0]                  ctrl_ia_status;
  logic [31:0]                  snapshot_ia_status;
  logic [31:0]                  count_ia_status;

  sa_ring_node u_sa_ring_node (.*,
    .locl_addr_o    (locl_addr),
    .locl_wr_strb_o (locl_wr_strb),
    .locl_wr_data_o (locl_wr_data),
    .locl_rd_strb_o (locl_rd_strb),
    .locl_rd_data_i (locl_rd_data),
    .locl_ack_i     (locl_ack),
    .locl_err_ack_i (locl_err_ack)
  );

  sa_regs u_sa_regs (
    .clk                  (clk),
    .rst_i                (rst_i),
    .locl_addr_i          (locl_addr),
    .locl_wr_strb_i       (locl_wr_strb),
    .locl_wr_data_i       (locl_wr_data),
    .locl_rd_strb_i       (locl_rd_strb),
    .locl_rd_data_o       (locl_rd_data),
    .locl_ack_o           (locl_ack),
    .locl_err_ack_o       (locl_err_ack),
    .reg_addr_o           (reg_addr),
    .reg_wr_data_o        (reg_wr_data),
    .reg_written_o        (reg_written),
    .sa_snap_o            (regs_sa_snap_o),
    .sa_clear_live_o      (regs_sa_clear_live_o),
    .ctrl_ia_wdata_o      (ctrl_ia_wdata),
    .ctrl_ia_rdata_i      (ctrl_ia_rdata),
    .snapshot_ia_rdata_i  (snapshot_ia_rdata),
    .count_ia_rdata_i     (count_ia_rdata),
    .ctrl_ia_status_i     (ctrl_ia_status),
    .snapshot_ia_status_i (snapshot_ia_status),
    .count_ia_status_i    (count_ia_status)
  );

  sa_indirect_access #(
    .CMND_ADDR (SA_CTRL_IA_CONFIG_ADDR),
    .WRITABLE  (1'b1),
    .ENTRY_T   (sa_ctrl_t)
  ) SA_CTRL (
    .clk           (clk),
    .rst_i         (rst_i),
    .reg_addr_i    (reg_addr),
    .reg_wr_data_i (reg_wr_data),
    .reg_written_i (reg_written),
    .wdata_i       (ctrl_ia_wdata),
    .mem_i         (regs_sa_ctrl_o), // ctrl entries live inside the window.
    .mem_o         (regs_sa_ctrl_o),
    .rdata_o       (ctrl_ia_rdata),
    .status_o      (ctrl_ia_status)
  );

  sa_indirect_access #(
    .CMND_ADDR (SA_SNAPSHOT_IA_CONFIG_ADDR),
    .WRITABLE  (1'b0),
    .ENTRY_T   (sa_stat_t)
  ) SA_SNAPSHOT (
    .clk           (clk),
    .rst_i         (rst_i),
    .reg_addr_i    (reg_addr),
    .reg_wr_data_i (reg_wr_data),
    .reg_written_i (reg_written),
    .wdata_i       ('0),
    .mem_i         (sa_snapshot_i),
    .mem_o         (),
    .rdata_o       (snapshot_ia_rdata),
    .status_o      (snapshot_ia_status)
  );

  sa_indirect_access #(
    .CMND_ADDR (SA_COUNT_IA_CONFIG_ADDR),
    .WRITABLE  (1'b0),
    .ENTRY_T   (sa_stat_t)
  ) SA_COUNT (
    .clk           (clk),
    .rst_i         (rst_i),
    .reg_addr_i    (reg_addr),
    .reg_wr_data_i (reg_wr_data),
    .reg_written_i (reg_written),
    .wdata_i       ('0),
    .mem_i         (sa_count_i),
    .mem_o         (),
    .rdata_o       (count_ia_rdata),
    .status_o      (count_ia_status)
  );

endmodule

// ==== src/sa_counters.sv ====
`timescale 1ns/1ps

module sa_counters (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic [sa_pkg::SA_N_EVENTS-1:0] sa_event_i,
  input  sa_pkg::sa_ctrl_t               sa_ctrl_i [sa_pkg::SA_N_ENTRIES],
  input  logic                           sa_snap_i,
  input  logic                           sa_clear_live_i,
  output sa_pkg::sa_stat_t               sa_count_o [sa_pkg::SA_N_ENTRIES],
  output sa_pkg::sa_stat_t               sa_snapshot_o [sa_pkg::SA_N_ENTRIES]
);
  import sa_pkg::*;

  logic [SA_N_ENTRIES-1:0] hit;

  for (genvar e = 0; e < SA_N_ENTRIES; e++) begin : g_entry
    assign hit[e] = sa_ctrl_i[e].enable && sa_event_i[sa_ctrl_i[e].event_sel];

    always_ff @(posedge clk) begin
      if (rst_i) begin
        sa_count_o[e]    <= '0;
        sa_snapshot_o[e] <= '0;
      end else begin
        if (sa_snap_i) begin
          sa_snapshot_o[e] <= sa_count_o[e]; // value before this cycle's event.
        end
        if (sa_clear_live_i) begin
          sa_count_o[e] <= '0;
        end else if (hit[e]) begin
          sa_count_o[e].count <= sa_count_o[e].count + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/sa_top.sv ====
`timescale 1ns/1ps

module sa_top (
  input  logic                              clk,
  input  logic                              rst_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0] rbus_addr_i,
  input  logic                              rbus_wr_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_wr_data_i,
  input  logic                              rbus_rd_strb_i,
  input  logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_rd_data_i,
  input  logic                              rbus_ack_i,
  input  logic                              rbus_err_ack_i,
  output logic [sa_pkg::RBUS_ADDR_BITS-1:0] rbus_addr_o,
  output logic                              rbus_wr_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_wr_data_o,
  output logic                              rbus_rd_strb_o,
  output logic [sa_pkg::RBUS_DATA_BITS-1:0] rbus_rd_data_o,
  output logic                              rbus_ack_o,
  output logic                              rbus_err_ack_o,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0] cfg_start_addr_i,
  input  logic [sa_pkg::RBUS_ADDR_BITS-1:0] cfg_end_addr_i,
  input  logic [sa_pkg::SA_N_EVENTS-1:0]    sa_event_i
);
  import sa_pkg::*;

  logic     sa_snap;
  logic     sa_clear_live;
  sa_ctrl_t sa_ctrl [SA_N_ENTRIES];
  sa_stat_t sa_count [SA_N_ENTRIES];
  sa_stat_t sa_snapshot [SA_N_ENTRIES];

  sa_regfile u_sa_regfile (.*,
    .regs_sa_snap_o       (sa_snap),
    .regs_sa_clear_live_o (sa_clear_live),
    .regs_sa_ctrl_o       (sa_ctrl),
    .sa_snapshot_i        (sa_snapshot),
    .sa_count_i           (sa_count)
  );

  sa_counters u_sa_counters (
    .clk             (clk),
    .rst_i           (rst_i),
    .sa_event_i      (sa_event_i),
    .sa_ctrl_i       (sa_ctrl),
    .sa_snap_i       (sa_snap),
    .sa_clear_live_i (sa_clear_live),
    .sa_count_o      (sa_count),
    .sa_snapshot_o   (sa_snapshot)
  );

endmodule

// ==== testbench/sa_tb.sv ====
`timescale 1ns/1ps

module sa_tb;
  import sa_pkg::*;

  localparam logic [15:0] BASE        = 16'h0100;
  localparam int          ACK_TIMEOUT = 10;

  logic        clk;
  logic        rst_i;
  logic [15:0] rbus_addr_i;
  logic        rbus_wr_strb_i;
  logic [31:0] rbus_wr_data_i;
  logic        rbus_rd_strb_i;
  logic [31:0] rbus_rd_data_i;
  logic        rbus_ack_i;
  logic        rbus_err_ack_i;
  logic [15:0] rbus_addr_o;
  logic        rbus_wr_strb_o;
  logic [31:0] rbus_wr_data_o;
  logic        rbus_rd_strb_o;
  logic [31:0] rbus_rd_data_o;
  logic        rbus_ack_o;
  logic        rbus_err_ack_o;
  logic [15:0] cfg_start_addr_i;
  logic [15:0] cfg_end_addr_i;
  logic [7:0]  sa_event_i;

  integer      seed;
  logic [3:0]  ctrl_model [16]; // {enable, event_sel} per entry.
  logic [63:0] snap_model [16];
  logic [7:0]  event_hist [$];
  logic [31:0] rd_word;
  logic [31:0] val;
  logic [63:0] val64;
  logic        rd_err;

  sa_top sa_top_inst (.*);

  always #20 clk = ~clk;

  // expected live count of one entry from its config and the events driven so far.
  function automatic logic [63:0] expected_count(input int e);
    logic [63:0] n;
    int          i;
    n = '0;
    for (i = 0; i < event_hist.size(); i++) begin
      if (ctrl_model[e][3] && event_hist[i][ctrl_model[e][2:0]]) begin
        n = n + 64'd1;
      end
    end
    return n;
  endfunction

  function automatic logic [31:0] ia_cmd(input logic [3:0] op, input logic [3:0] idx);
    return {op, 24'b0, idx};
  endfunction

  function automatic logic [31:0] ia_status(input logic [2:0] code, input logic [3:0] idx);
    return {code, 25'b0, idx};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one strobe, then wait for ack or err_ack at the ring output.
  task automatic ring_access(input logic wr, input logic [7:0] off, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
    int n;
    rbus_addr_i    = BASE | {8'b0, off};
    rbus_wr_data_i = wdata;
    rbus_wr_strb_i = wr;
    rbus_rd_strb_i = !wr;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      rbus_wr_strb_i = 1'b0;
      rbus_rd_strb_i = 1'b0;
      n++;
    end while (!rbus_ack_o && !rbus_err_ack_o && n < ACK_TIMEOUT);
    if (!rbus_ack_o && !rbus_err_ack_o) begin
      $display("Errors found");
      $fatal(1, "no ack from the ring for offset %h", off);
    end
    check_value("ack latency", 64'(n), 64'd3); // node, regs, node output.
    rdata = rbus_rd_data_o;
    err   = rbus_err_ack_o;
  endtask

  task automatic ring_write(input logic [7:0] off, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    ring_access(1'b1, off, data, unused, err);
    check_value("rbus_err_ack_o", {63'b0, err}, 64'd0);
  endtask

  task automatic ring_read(input logic [7:0] off, output logic [31:0] data);
    logic err;
    ring_access(1'b0, off, 32'b0, data, err);
    check_value("rbus_err_ack_o", {63'b0, err}, 64'd0);
  endtask

  task automatic ctrl_write(input logic [3:0] idx, input logic [3:0] entry);
    ring_write(SA_CTRL_IA_WDATA_ADDR, {28'b0, entry});
    ring_write(SA_CTRL_IA_CONFIG_ADDR, ia_cmd(4'd2, idx));
  endtask

  // read one 50-bit entry through a read-only window as low and high words.
  task automatic stat_read(input logic [7:0] cfg_off, input logic [7:0] lo_off,
                           input logic [3:0] idx, output logic [63:0] data);
    logic [31:0] lo;
    logic [31:0] hi;
    ring_write(cfg_off, ia_cmd(4'd1, idx));
    ring_read(lo_off, lo);
    ring_read(lo_off + 8'h04, hi);
    data = {hi, lo};
  endtask

  initial begin
    seed             = 32'h8157_69db;
    clk              = 1'b0;
    rst_i            = 1'b1;
    rbus_addr_i      = '0;
    rbus_wr_strb_i   = 1'b0;
    rbus_wr_data_i   = '0;
    rbus_rd_strb_i   = 1'b0;
    rbus_rd_data_i   = '0;
    rbus_ack_i       = 1'b0;
    rbus_err_ack_i   = 1'b0;
    cfg_start_addr_i = 16'h0100;
    cfg_end_addr_i   = 16'h01FF;
    sa_event_i       = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;

    ring_read(SA_REVISION_ADDR, rd_word);
    check_value("revision", rd_word, 64'h01);
    val = $random(seed);
    ring_write(SA_SPARE_ADDR, val);
    ring_read(SA_SPARE_ADDR, rd_word);
    check_value("spare", rd_word, val);

    // out-of-range read passes through the node.
    rbus_addr_i    = 16'h0300;
    rbus_rd_strb_i = 1'b1;
    @(posedge clk);
    #1;
    rbus_rd_strb_i = 1'b0;
    check_value("rbus_rd_strb_o", rbus_rd_strb_o, 64'd1);
    check_value("rbus_wr_strb_o", rbus_wr_strb_o, 64'd0);
    check_value("rbus_addr_o", rbus_addr_o, 64'h0300);
    repeat (3) begin
      check_value("rbus_ack_o", rbus_ack_o, 64'd0);
      check_value("rbus_err_ack_o", rbus_err_ack_o, 64'd0);
      @(posedge clk);
      #1;
    end
    // out-of-range write passes through with its data.
    val            = $random(seed);
    rbus_wr_data_i = val;
    rbus_wr_strb_i = 1'b1;
    @(posedge clk);
    #1;
    rbus_wr_strb_i = 1'b0;
    check_value("rbus_wr_strb_o", rbus_wr_strb_o, 64'd1);
    check_value("rbus_rd_strb_o", rbus_rd_strb_o, 64'd0);
    check_value("rbus_wr_data_o", rbus_wr_data_o, val);
    check_value("rbus_ack_o", rbus_ack_o, 64'd0);
    val            = $random(seed);
    rbus_rd_data_i = val;
    rbus_ack_i     = 1'b1; // upstream ack.
    @(posedge clk);
    #1;
    rbus_ack_i     = 1'b0;
    rbus_rd_data_i = '0;
    check_value("rbus_ack_o", rbus_ack_o, 64'd1);
    check_value("rbus_rd_data_o", rbus_rd_data_o, val);
    @(posedge clk);
    #1;

    for (int e = 0; e < 16; e++) begin
      ctrl_model[e] = 4'($random(seed));
      ctrl_write(4'(e), ctrl_model[e]);
    end
    for (int e = 0; e < 16; e++) begin
      ring_write(SA_CTRL_IA_CONFIG_ADDR, ia_cmd(4'd1, 4'(e)));
      ring_read(SA_CTRL_IA_RDATA_ADDR, rd_word);
      check_value("ctrl rdata", rd_word, {60'b0, ctrl_model[e]});
      ring_read(SA_CTRL_IA_STATUS_ADDR, rd_word);
      check_value("ctrl status", rd_word, ia_status(3'd0, 4'(e)));
    end

    for (int e = 0; e < 16; e++) begin
      ctrl_model[e] = 4'($random(seed));
      ctrl_write(4'(e), ctrl_model[e]);
    end
    repeat (200) begin
      @(posedge clk);
      #1;
      sa_event_i = 8'($random(seed));
      event_hist.push_back(sa_event_i);
    end
    @(posedge clk);
    #1;
    sa_event_i = '0;
    ring_write(SA_GLOBAL_CTRL_ADDR, 32'h1); // snap.
    for (int e = 0; e < 16; e++) begin
      snap_model[e] = expected_count(e);
      stat_read(SA_SNAPSHOT_IA_CONFIG_ADDR, SA_SNAPSHOT_IA_RDATA_LO_ADDR, 4'(e), val64);
      check_value("snapshot", val64, snap_model[e]);
    end

    for (int e = 0; e < 16; e++) begin
      stat_read(SA_COUNT_IA_CONFIG_ADDR, SA_COUNT_IA_RDATA_LO_ADDR, 4'(e), val64);
      check_value("count", val64, expected_count(e));
    end
    ring_write(SA_GLOBAL_CTRL_ADDR, 32'h2); // clear_live.
    event_hist.delete();
    for (int e = 0; e < 16; e++) begin
      stat_read(SA_COUNT_IA_CONFIG_ADDR, SA_COUNT_IA_RDATA_LO_ADDR, 4'(e), val64);
      check_value("count after clear", val64, expected_count(e));
      stat_read(SA_SNAPSHOT_IA_CONFIG_ADDR, SA_SNAPSHOT_IA_RDATA_LO_ADDR, 4'(e), val64);
      check_value("snapshot after clear", val64, snap_model[e]);
    end

    ring_access(1'b0, 8'h40, 32'b0, rd_word, rd_err);
    check_value("unmapped err_ack", {63'b0, rd_err}, 64'd1);
    check_value("unmapped rd_data", rd_word, 64'd0);
    ring_write(SA_SNAPSHOT_IA_CONFIG_ADDR, ia_cmd(4'd2, 4'd5));
    ring_read(SA_SNAPSHOT_IA_STATUS_ADDR, rd_word);
    check_value("snapshot status", rd_word, ia_status(3'd1, 4'd5));
    ring_write(SA_CTRL_IA_WDATA_ADDR, {28'b0, ~ctrl_model[9]});
    ring_write(SA_CTRL_IA_CONFIG_ADDR, ia_cmd(4'd7, 4'd9));
    ring_read(SA_CTRL_IA_STATUS_ADDR, rd_word);
    check_value("ctrl status", rd_word, ia_status(3'd1, 4'd9));
    ring_write(SA_CTRL_IA_CONFIG_ADDR, ia_cmd(4'd1, 4'd9));
    ring_read(SA_CTRL_IA_RDATA_ADDR, rd_word);
    check_value("ctrl rdata", rd_word, {60'b0, ctrl_model[9]}); // entry untouched.

    $display("No errors");
    $finish;
  end

endmodule

// ==== sources.f ====
src/sa_pkg.sv
src/sa_ring_node.sv
src/sa_regs.sv
src/sa_indirect_access.sv
src/sa_regfile.sv
src/sa_counters.sv
src/sa_top.sv
testbench/sa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the sa_tb simulation with verilator, run it and search the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module sa_tb -f sources.f -o sa_tb_sim \
  && ./obj_dir/sa_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
